// ==== hdl/noc_ni_macros.svh ====
`ifndef NOC_NI_MACROS_SVH
`define NOC_NI_MACROS_SVH

// Flit layout. Two type bits sit above the data field.
`define FLIT_WIDTH 34
`define FLIT_DATA 32
// The packet size rides in the top bits of the head flit data.
`define PKT_WIDTH 8

// Virtual channels of the local port.
`define N_VIRT_CHN 2
`define VC_WIDTH 1

// Queue depths; both must be powers of two so the pointers wrap freely.
`define RX_DEPTH 4
`define RX_CNT_WIDTH 3
`define LB_DEPTH 4

// Wishbone byte addresses of the host registers.
`define ADR_WIDTH 5
`define REG_TX_VC0 5'h00
`define REG_TX_VC1 5'h04
`define REG_TX_SIZE 5'h08
`define REG_RX_VC0 5'h10
`define REG_RX_VC1 5'h14
`define REG_STATUS 5'h18

`endif

// ==== hdl/noc_ni_pkg.sv ====
`include "noc_ni_macros.svh"

package noc_ni_pkg;

  // Flit type codes carried in the upper bits of every flit.
  // The width follows from the flit and data widths.
  typedef enum logic [`FLIT_WIDTH-`FLIT_DATA-1:0] {
    HEAD_FLIT = 2'd0,
    BODY_FLIT = 2'd1,
    TAIL_FLIT = 2'd2
  } flit_type_t;

  // Head flit view.
  // The packet size replaces the upper data bits of the first word.
  typedef struct packed {
    flit_type_t                       flit_type;
    logic [`PKT_WIDTH-1:0]            pkt_sz;
    logic [`FLIT_DATA-`PKT_WIDTH-1:0] head_data;
  } head_flit_t;

  // Body and tail flit view.
  // The whole data field is payload here.
  typedef struct packed {
    flit_type_t             flit_type;
    logic [`FLIT_DATA-1:0]  data;
  } body_flit_t;

  // One flit word seen either way.
  // The type field lines up in both views, so a receiver may read it
  // through the body view before it knows which kind of flit it holds.
  typedef union packed {
    head_flit_t head;
    body_flit_t body;
  } flit_t;

endpackage

// ==== hdl/wb_ni_slave.sv ====
`timescale 1ns/10ps
`include "noc_ni_macros.svh"

module wb_ni_slave (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  logic [`ADR_WIDTH-1:0]    adr,
  input  logic [`FLIT_DATA-1:0]    dat_w,
  output logic [`FLIT_DATA-1:0]    dat_r,
  output logic                     ack,
  output logic                     pkt_out_valid,
  output logic                     pkt_out_new,
  output logic                     pkt_out_last,
  output logic [`FLIT_DATA-1:0]    pkt_out_data,
  output logic [`PKT_WIDTH-1:0]    pkt_out_sz,
  output logic [`VC_WIDTH-1:0]     pkt_out_vc,
  input  logic                     pkt_out_ready,
  output logic                     rx_pop,
  output logic [`VC_WIDTH-1:0]     rx_pop_vc,
  input  logic [`FLIT_DATA-1:0]    rx_head_vc0,
  input  logic [`FLIT_DATA-1:0]    rx_head_vc1,
  input  logic [`RX_CNT_WIDTH-1:0] rx_count_vc0,
  input  logic [`RX_CNT_WIDTH-1:0] rx_count_vc1
);

  // Size of the open packet and the flits still to be sent for it.
  logic [`PKT_WIDTH-1:0] pkt_size;
  logic [`PKT_WIDTH-1:0] rem_flits;
  logic                  pkt_open;

  logic                  req;
  logic                  tx_data_sel;
  logic                  rx_data_sel;
  logic [`FLIT_DATA-1:0] rd_data;

  // A new request is taken only when no ack is on the bus and no TX word
  // is waiting on the processor. The host keeps stb high through the ack
  // cycle, so the ack term keeps one access from being seen twice.
  assign req = cyc && stb && !ack && !pkt_out_valid;

  assign tx_data_sel = (adr == `REG_TX_VC0) || (adr == `REG_TX_VC1);
  assign rx_data_sel = (adr == `REG_RX_VC0) || (adr == `REG_RX_VC1);

  // The first flit is the one sent while the counter still equals the size.
  // Framing state is frozen while valid is high, so these stay stable.
  assign pkt_out_new  = (rem_flits == pkt_size);
  assign pkt_out_last = (rem_flits == `PKT_WIDTH'(1));
  assign pkt_out_sz   = pkt_size;

  // An RX read pops the buffer on the same edge that captures its head.
  // A pop of an empty channel is ignored by the buffer.
  assign rx_pop    = req && !we && rx_data_sel;
  assign rx_pop_vc = (adr == `REG_RX_VC1) ? 1'b1 : 1'b0;

  // Read data mux.
  // Empty channels read as zero instead of stale FIFO contents.
  always_comb begin
    rd_data = '0;
    case (adr)
      `REG_TX_SIZE: rd_data = {{(`FLIT_DATA-`PKT_WIDTH){1'b0}}, pkt_size};
      `REG_RX_VC0:  rd_data = (rx_count_vc0 != '0) ? rx_head_vc0 : '0;
      `REG_RX_VC1:  rd_data = (rx_count_vc1 != '0) ? rx_head_vc1 : '0;
      `REG_STATUS:  rd_data = {23'd0, pkt_open, 1'b0, rx_count_vc1, 1'b0, rx_count_vc0};
      default:      rd_data = '0;
    endcase
  end

  // Bus handshake and packet sequencing.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack           <= 1'b0;
      pkt_out_valid <= 1'b0;
      pkt_open      <= 1'b0;
      pkt_size      <= '0;
      rem_flits     <= '0;
    end else begin
      // Ack is a single-cycle pulse.
      ack <= 1'b0;
      if (pkt_out_valid && pkt_out_ready) begin
        // The flit has left; ack the write one cycle after the handshake.
        pkt_out_valid <= 1'b0;
        ack           <= 1'b1;
        rem_flits     <= rem_flits - 1'b1;
        if (rem_flits == `PKT_WIDTH'(1)) begin
          pkt_open <= 1'b0;
        end
      end else if (req) begin
        if (we && tx_data_sel && pkt_open) begin
          // Hold the write until the processor takes the flit.
          pkt_out_valid <= 1'b1;
        end else begin
          // Everything else, including a TX write with no open packet,
          // is acked right away.
          ack <= 1'b1;
        end
        if (we && (adr == `REG_TX_SIZE)) begin
          // A size of zero leaves the packet closed.
          pkt_size  <= dat_w[`PKT_WIDTH-1:0];
          rem_flits <= dat_w[`PKT_WIDTH-1:0];
          pkt_open  <= |dat_w[`PKT_WIDTH-1:0];
        end
      end
    end
  end

  // Payload capture for TX words and read data.
  always_ff @(posedge clk) begin
    if (req && we && tx_data_sel) begin
      pkt_out_data <= dat_w;
      pkt_out_vc   <= (adr == `REG_TX_VC1) ? 1'b1 : 1'b0;
    end
    if (req && !we) begin
      dat_r <= rd_data;
    end
  end

endmodule

// ==== hdl/pkt_proc.sv ====
`timescale 1ns/10ps
`include "noc_ni_macros.svh"

module pkt_proc (
  input  logic                  pkt_out_valid,
  input  logic                  pkt_out_new,
  input  logic                  pkt_out_last,
  input  logic [`FLIT_DATA-1:0] pkt_out_data,
  input  logic [`PKT_WIDTH-1:0] pkt_out_sz,
  input  logic [`VC_WIDTH-1:0]  pkt_out_vc,
  output logic                  pkt_out_ready,
  output logic                  send_valid,
  output noc_ni_pkg::flit_t     send_flit,
  output logic [`VC_WIDTH-1:0]  send_vc,
  input  logic                  send_ready,
  input  logic                  recv_valid,
  input  noc_ni_pkg::flit_t     recv_flit,
  input  logic [`VC_WIDTH-1:0]  recv_vc,
  output logic                  recv_ready,
  output logic                  rx_valid,
  output logic [`FLIT_DATA-1:0] rx_data,
  output logic [`VC_WIDTH-1:0]  rx_vc,
  input  logic                  rx_ready
);
  import noc_ni_pkg::*;

  // Send side handshake goes straight to the router port.
  assign send_valid    = pkt_out_valid;
  assign send_vc       = pkt_out_vc;
  assign pkt_out_ready = send_ready;

  // Flit framing.
  // A new packet wins over last, so a one-flit packet goes out as a head.
  always_comb begin
    send_flit = '0;
    if (pkt_out_new) begin
      send_flit.head.flit_type = HEAD_FLIT;
      send_flit.head.pkt_sz    = pkt_out_sz;
      send_flit.head.head_data = pkt_out_data[`FLIT_DATA-`PKT_WIDTH-1:0];
    end else if (pkt_out_last) begin
      send_flit.body.flit_type = TAIL_FLIT;
      send_flit.body.data      = pkt_out_data;
    end else begin
      send_flit.body.flit_type = BODY_FLIT;
      send_flit.body.data      = pkt_out_data;
    end
  end

  // Receive side.
  // The type bits are dropped and the whole data field is kept, so a head
  // word still shows its size in the upper bits.
  assign rx_valid   = recv_valid;
  assign rx_data    = recv_flit.body.data;
  assign rx_vc      = recv_vc;
  assign recv_ready = rx_ready;

endmodule

// ==== hdl/noc_loopback.sv ====
`timescale 1ns/10ps
`include "noc_ni_macros.svh"

module noc_loopback (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 send_valid,
  input  noc_ni_pkg::flit_t    send_flit,
  input  logic [`VC_WIDTH-1:0] send_vc,
  output logic                 send_ready,
  output logic                 recv_valid,
  output noc_ni_pkg::flit_t    recv_flit,
  output logic [`VC_WIDTH-1:0] recv_vc,
  input  logic                 recv_ready
);
  import noc_ni_pkg::*;

  localparam int PTR_W = $clog2(`LB_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // Flit and channel storage of the modelled router port.
  flit_t                flit_mem [`LB_DEPTH];
  logic [`VC_WIDTH-1:0] vc_mem [`LB_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign send_ready = (count != CNT_W'(`LB_DEPTH));
  assign recv_valid = (count != '0);
  assign push       = send_valid && send_ready;
  assign pop        = recv_valid && recv_ready;

  // The oldest flit is offered from the cycle after it was stored.
  assign recv_flit = flit_mem[rd_ptr];
  assign recv_vc   = vc_mem[rd_ptr];

  // Pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      flit_mem[wr_ptr] <= send_flit;
      vc_mem[wr_ptr]   <= send_vc;
    end
  end

endmodule

// ==== hdl/rx_vc_buffer.sv ====
`timescale 1ns/10ps
`include "noc_ni_macros.svh"

module rx_vc_buffer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rx_valid,
  input  logic [`FLIT_DATA-1:0]    rx_data,
  input  logic [`VC_WIDTH-1:0]     rx_vc,
  output logic                     rx_ready,
  input  logic                     rx_pop,
  input  logic [`VC_WIDTH-1:0]     rx_pop_vc,
  output logic [`FLIT_DATA-1:0]    rx_head_vc0,
  output logic [`FLIT_DATA-1:0]    rx_head_vc1,
  output logic [`RX_CNT_WIDTH-1:0] rx_count_vc0,
  output logic [`RX_CNT_WIDTH-1:0] rx_count_vc1
);

  localparam int PTR_W = $clog2(`RX_DEPTH);

  // One small FIFO per virtual channel.
  logic [`FLIT_DATA-1:0]    mem [`N_VIRT_CHN][`RX_DEPTH];
  logic [PTR_W-1:0]         wr_ptr [`N_VIRT_CHN];
  logic [PTR_W-1:0]         rd_ptr [`N_VIRT_CHN];
  logic [`RX_CNT_WIDTH-1:0] count [`N_VIRT_CHN];
  logic [`N_VIRT_CHN-1:0]   push;
  logic [`N_VIRT_CHN-1:0]   pop;

  // Ready follows the channel of the word on offer.
  // A full channel blocks the loopback queue behind it.
  assign rx_ready = (count[rx_vc] != `RX_CNT_WIDTH'(`RX_DEPTH));

  // Per-channel push and pop strobes.
  // A pop of an empty channel does nothing.
  always_comb begin
    for (int i = 0; i < `N_VIRT_CHN; i++) begin
      push[i] = rx_valid && rx_ready && (rx_vc == `VC_WIDTH'(i));
      pop[i]  = rx_pop && (rx_pop_vc == `VC_WIDTH'(i)) && (count[i] != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `N_VIRT_CHN; i++) begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
        count[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < `N_VIRT_CHN; i++) begin
        if (push[i]) begin
          wr_ptr[i] <= wr_ptr[i] + 1'b1;
        end
        if (pop[i]) begin
          rd_ptr[i] <= rd_ptr[i] + 1'b1;
        end
        case ({push[i], pop[i]})
          2'b10:   count[i] <= count[i] + 1'b1;
          2'b01:   count[i] <= count[i] - 1'b1;
          default: count[i] <= count[i];
        endcase
      end
    end
  end

  // Data storage.
  always_ff @(posedge clk) begin
    for (int i = 0; i < `N_VIRT_CHN; i++) begin
      if (push[i]) begin
        mem[i][wr_ptr[i]] <= rx_data;
      end
    end
  end

  // Heads and fill levels for the host read path.
  assign rx_head_vc0  = mem[0][rd_ptr[0]];
  assign rx_head_vc1  = mem[1][rd_ptr[1]];
  assign rx_count_vc0 = count[0];
  assign rx_count_vc1 = count[1];

endmodule

// ==== hdl/noc_ni_top.sv ====
`timescale 1ns/10ps
`include "noc_ni_macros.svh"

module noc_ni_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`ADR_WIDTH-1:0] adr,
  input  logic [`FLIT_DATA-1:0] dat_w,
  output logic [`FLIT_DATA-1:0] dat_r,
  output logic                  ack
);
  import noc_ni_pkg::*;

  // Host side to packet processor.
  logic                  pkt_out_valid;
  logic                  pkt_out_new;
  logic                  pkt_out_last;
  logic [`FLIT_DATA-1:0] pkt_out_data;
  logic [`PKT_WIDTH-1:0] pkt_out_sz;
  logic [`VC_WIDTH-1:0]  pkt_out_vc;
  logic                  pkt_out_ready;

  // Packet processor to and from the router port model.
  logic                  send_valid;
  flit_t                 send_flit;
  logic [`VC_WIDTH-1:0]  send_vc;
  logic                  send_ready;
  logic                  recv_valid;
  flit_t                 recv_flit;
  logic [`VC_WIDTH-1:0]  recv_vc;
  logic                  recv_ready;

  // Received words into the per-channel buffer.
  logic                     rx_valid;
  logic [`FLIT_DATA-1:0]    rx_data;
  logic [`VC_WIDTH-1:0]     rx_vc;
  logic                     rx_ready;
  logic                     rx_pop;
  logic [`VC_WIDTH-1:0]     rx_pop_vc;
  logic [`FLIT_DATA-1:0]    rx_head_vc0;
  logic [`FLIT_DATA-1:0]    rx_head_vc1;
  logic [`RX_CNT_WIDTH-1:0] rx_count_vc0;
  logic [`RX_CNT_WIDTH-1:0] rx_count_vc1;

  wb_ni_slave u_wb_ni_slave (
    .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
    .pkt_out_valid, .pkt_out_new, .pkt_out_last, .pkt_out_data,
    .pkt_out_sz, .pkt_out_vc, .pkt_out_ready,
    .rx_pop, .rx_pop_vc, .rx_head_vc0, .rx_head_vc1,
    .rx_count_vc0, .rx_count_vc1
  );

  pkt_proc u_pkt_proc (
    .pkt_out_valid, .pkt_out_new, .pkt_out_last, .pkt_out_data,
    .pkt_out_sz, .pkt_out_vc, .pkt_out_ready,
    .send_valid, .send_flit, .send_vc, .send_ready,
    .recv_valid, .recv_flit, .recv_vc, .recv_ready,
    .rx_valid, .rx_data, .rx_vc, .rx_ready
  );

  // Stands in for the router and turns every sent flit around.
  noc_loopback u_noc_loopback (
    .clk, .rst_n,
    .send_valid, .send_flit, .send_vc, .send_ready,
    .recv_valid, .recv_flit, .recv_vc, .recv_ready
  );

  rx_vc_buffer u_rx_vc_buffer (
    .clk, .rst_n, .rx_valid, .rx_data, .rx_vc, .rx_ready,
    .rx_pop, .rx_pop_vc, .rx_head_vc0, .rx_head_vc1,
    .rx_count_vc0, .rx_count_vc1
  );

endmodule

// ==== sim/noc_ni_tb.sv ====
`timescale 1ns/10ps
`include "noc_ni_macros.svh"

module noc_ni_tb;

  // Cycle limits for a single bus access and for STATUS polling.
  localparam int ACK_LIMIT  = 200;
  localparam int POLL_LIMIT = 40;

  logic                  clk;
  logic                  rst_n;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [`ADR_WIDTH-1:0] adr;
  logic [`FLIT_DATA-1:0] dat_w;
  logic [`FLIT_DATA-1:0] dat_r;
  logic                  ack;

  int     data_errs;
  int     timeout_errs;
  int     proto_errs;
  integer seed;

  // Reference model: one queue of expected words per virtual channel,
  // plus the size and remaining flits of the open packet.
  logic [`FLIT_DATA-1:0] exp_q0[$];
  logic [`FLIT_DATA-1:0] exp_q1[$];
  int                    pkt_size_m;
  int                    pkt_left_m;

  noc_ni_top UUT (
    .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Ack is a one-cycle pulse.
  ack_width: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
    else begin
      $display("Ack stayed high for more than one cycle at time %0t", $time);
      proto_errs = proto_errs + 1;
    end

  // Ack only answers a request that is on the bus.
  ack_cause: assert property (@(posedge clk) disable iff (!rst_n)
                              $rose(ack) |-> $past(cyc && stb))
    else begin
      $display("Ack rose without a bus request at time %0t", $time);
      proto_errs = proto_errs + 1;
    end

  // Waits for ack, checking 1 ns after each rising edge.
  task automatic wait_ack(input logic [`ADR_WIDTH-1:0] a);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    while (!ack && waited < ACK_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!ack) begin
      $display("No ack from address %h within %0d cycles at time %0t", a, ACK_LIMIT, $time);
      timeout_errs++;
    end
    // The request is dropped in the ack cycle so it is not taken twice.
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic bus_write(input logic [`ADR_WIDTH-1:0] a, input logic [`FLIT_DATA-1:0] d);
    @(posedge clk);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = a;
    dat_w = d;
    wait_ack(a);
  endtask

  task automatic bus_read(input logic [`ADR_WIDTH-1:0] a, output logic [`FLIT_DATA-1:0] d);
    @(posedge clk);
    #1;
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = a;
    wait_ack(a);
    d = dat_r;
  endtask

  // Reads one register and compares it with the expected word.
  task automatic check_read(input logic [`ADR_WIDTH-1:0] a, input logic [`FLIT_DATA-1:0] exp);
    logic [`FLIT_DATA-1:0] got;
    bus_read(a, got);
    assert (got == exp) else begin
      $display("Fail time=%0t dat_r expected=%h actual=%h", $time, exp, got);
      data_errs++;
    end
  endtask

  // Opens a packet of n flits in the DUT and in the model.
  task automatic open_packet(input int n);
    bus_write(`REG_TX_SIZE, n);
    pkt_size_m = n;
    pkt_left_m = n;
  endtask

  // Sends one random word and predicts the word the host will read back.
  // The first word of a packet carries the size in its top bits.
  task automatic send_word(input int vc);
    logic [`FLIT_DATA-1:0] d;
    logic [`FLIT_DATA-1:0] word;
    d = $random(seed);
    bus_write((vc == 1) ? `REG_TX_VC1 : `REG_TX_VC0, d);
    if (pkt_left_m != 0) begin
      word = d;
      if (pkt_left_m == pkt_size_m) begin
        word = {pkt_size_m[`PKT_WIDTH-1:0], d[`FLIT_DATA-`PKT_WIDTH-1:0]};
      end
      if (vc == 1) begin
        exp_q1.push_back(word);
      end else begin
        exp_q0.push_back(word);
      end
      pkt_left_m--;
    end
  endtask

  // Reads one word from a receive channel; an empty one reads as zero.
  task automatic read_rx(input int vc);
    logic [`FLIT_DATA-1:0] exp;
    exp = '0;
    if (vc == 1) begin
      if (exp_q1.size() != 0) begin
        exp = exp_q1.pop_front();
      end
      check_read(`REG_RX_VC1, exp);
    end else begin
      if (exp_q0.size() != 0) begin
        exp = exp_q0.pop_front();
      end
      check_read(`REG_RX_VC0, exp);
    end
  endtask

  // Expected STATUS word.
  // Words beyond the FIFO depth are still waiting in the loopback queue.
  function automatic logic [`FLIT_DATA-1:0] status_model();
    int c0;
    int c1;
    c0 = (exp_q0.size() > `RX_DEPTH) ? `RX_DEPTH : exp_q0.size();
    c1 = (exp_q1.size() > `RX_DEPTH) ? `RX_DEPTH : exp_q1.size();
    status_model      = '0;
    status_model[2:0] = c0[2:0];
    status_model[6:4] = c1[2:0];
    status_model[8]   = (pkt_left_m != 0);
  endfunction

  // Polls STATUS until it matches the model or the poll limit runs out.
  task automatic poll_status();
    logic [`FLIT_DATA-1:0] exp;
    logic [`FLIT_DATA-1:0] got;
    int                    tries;
    exp   = status_model();
    tries = 0;
    bus_read(`REG_STATUS, got);
    while (got != exp && tries < POLL_LIMIT) begin
      bus_read(`REG_STATUS, got);
      tries++;
    end
    assert (got == exp) else begin
      $display("Fail time=%0t dat_r expected=%h actual=%h", $time, exp, got);
      data_errs++;
    end
  endtask

  initial begin
    seed         = 61;
    data_errs    = 0;
    timeout_errs = 0;
    proto_errs   = 0;
    pkt_size_m   = 0;
    pkt_left_m   = 0;
    rst_n        = 1'b0;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    dat_w        = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Nothing is buffered and no packet is open after reset.
    check_read(`REG_STATUS, '0);

    // One packet of four flits on VC0.
    open_packet(4);
    // The open packet shows in STATUS before any word is sent.
    poll_status();
    repeat (4) send_word(0);
    poll_status();
    repeat (4) read_rx(0);

    // Packets alternate between the channels and must not mix.
    open_packet(2);
    repeat (2) send_word(0);
    open_packet(3);
    repeat (3) send_word(1);
    open_packet(2);
    repeat (2) send_word(0);
    poll_status();
    repeat (3) read_rx(1);
    repeat (4) read_rx(0);

    // Eight words fill the VC1 FIFO and then the loopback queue behind it.
    // The reads free space so the stalled words move up in order.
    open_packet(8);
    repeat (8) send_word(1);
    poll_status();
    repeat (8) read_rx(1);

    // A one-flit packet is a head word, and a write with no open packet
    // leaves no word behind.
    open_packet(1);
    send_word(0);
    send_word(1);
    poll_status();
    read_rx(0);
    read_rx(1);
    read_rx(0);

    $display("Error count: %0d data, %0d timeout, %0d protocol",
             data_errs, timeout_errs, proto_errs);
    if (data_errs + timeout_errs + proto_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== noc_ni_top.f ====
+incdir+hdl
hdl/noc_ni_pkg.sv
hdl/wb_ni_slave.sv
hdl/pkt_proc.sv
hdl/noc_loopback.sv
hdl/rx_vc_buffer.sv
hdl/noc_ni_top.sv
sim/noc_ni_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the network interface testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module noc_ni_tb \
  -f noc_ni_top.f -o noc_ni_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/noc_ni_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  exit 1
fi

if ! grep -q "all tests passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0
